/* all.f */
verilog/rt_pkg.sv
verilog/tri_mem.sv
verilog/isect_core.sv
verilog/ic_mem_manager.sv
verilog/isect_top.sv
verification/isect_assertions.sv
verification/isect_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = isect_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJ_DIR)

/* verification/isect_tb.sv */
`timescale 1ns/1ps

module isect_tb;

  localparam int vec_bits   = 96;
  localparam int lane_bits  = 32;
  localparam int coord_bits = 10;
  localparam int sid_bits   = 32;
  localparam int ntri       = rt_pkg::num_tri;
  localparam int tid_bits   = rt_pkg::thread_w;
  localparam int addr_bits  = $clog2(ntri);

  // ray and load budget for the timeout
  localparam int rand_rounds = 20;
  localparam int num_rays    = 9 + rand_rounds;
  localparam int num_loads   = 6 + rand_rounds;
  localparam int limit = num_rays * (4 * ntri + 10) + num_loads * (ntri + 1) + 8 + 4;

  typedef struct packed {
    longint x;
    longint y;
    longint z;
  } v3_t;

  logic                 clk;
  logic                 rst;
  logic                 ray_start;
  logic [vec_bits-1:0]  orig_in;
  logic [vec_bits-1:0]  dir_in;
  logic [tid_bits-1:0]  thread_id_in;
  logic                 tri_we;
  logic [addr_bits-1:0] tri_waddr;
  logic [vec_bits-1:0]  tri_v0_w;
  logic [vec_bits-1:0]  tri_v1_w;
  logic [vec_bits-1:0]  tri_v2_w;
  logic [sid_bits-1:0]  tri_sid_w;
  logic                 ray_ready;
  logic                 result_valid;
  logic [tid_bits-1:0]  thread_id_out;
  logic [vec_bits-1:0]  hit_v0;
  logic [vec_bits-1:0]  hit_v1;
  logic [vec_bits-1:0]  hit_v2;
  logic [vec_bits-1:0]  hit_norm;
  logic [sid_bits-1:0]  hit_sid;

  // shadow of the triangle store
  logic [vec_bits-1:0] tri_v0 [ntri];
  logic [vec_bits-1:0] tri_v1 [ntri];
  logic [vec_bits-1:0] tri_v2 [ntri];
  logic [sid_bits-1:0] tri_sid [ntri];

  logic [vec_bits-1:0] exp_v0;
  logic [vec_bits-1:0] exp_v1;
  logic [vec_bits-1:0] exp_v2;
  logic [vec_bits-1:0] exp_norm;
  logic [sid_bits-1:0] exp_sid;

  int seed;
  int cycles = 0;

  isect_top dut (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run went past %0d cycles without finishing", limit);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s = %0h, expected %0h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  //////////////////////////////
  // vectors and reference model
  //////////////////////////////
  function automatic logic [vec_bits-1:0] vec(input int x, input int y, input int z);
    return {z, y, x}; // x in the low lane
  endfunction

  function automatic longint lane(input logic [vec_bits-1:0] v, input int i);
    return longint'($signed(v[i*lane_bits +: coord_bits]));
  endfunction

  function automatic v3_t to_v3(input logic [vec_bits-1:0] v);
    v3_t r;
    r.x = lane(v, 0);
    r.y = lane(v, 1);
    r.z = lane(v, 2);
    return r;
  endfunction

  function automatic v3_t minus(input v3_t a, input v3_t b);
    return '{a.x - b.x, a.y - b.y, a.z - b.z};
  endfunction

  function automatic v3_t cross3(input v3_t a, input v3_t b);
    return '{a.y * b.z - a.z * b.y, a.z * b.x - a.x * b.z, a.x * b.y - a.y * b.x};
  endfunction

  function automatic longint dot3(input v3_t a, input v3_t b);
    return a.x * b.x + a.y * b.y + a.z * b.z;
  endfunction

  task automatic predict(input logic [vec_bits-1:0] o, input logic [vec_bits-1:0] d);
    v3_t org;
    v3_t dr;
    v3_t a;
    v3_t e1;
    v3_t e2;
    v3_t s;
    v3_t p;
    v3_t q;
    v3_t n;
    longint det;
    longint u;
    longint v;
    longint t;
    longint best_t;
    longint best_det;
    logic found;
    org = to_v3(o);
    dr = to_v3(d);
    found = 1'b0;
    best_t = 0;
    best_det = 1;
    exp_sid = '0; // a miss leaves everything zero
    exp_v0 = '0;
    exp_v1 = '0;
    exp_v2 = '0;
    exp_norm = '0;
    for (int i = 0; i < ntri; i++) begin
      a = to_v3(tri_v0[i]);
      e1 = minus(to_v3(tri_v1[i]), a);
      e2 = minus(to_v3(tri_v2[i]), a);
      s = minus(org, a);
      p = cross3(dr, e2);
      q = cross3(s, e1);
      det = dot3(e1, p);
      u = dot3(s, p);
      v = dot3(dr, q);
      t = dot3(e2, q);
      // hit rule plus the strictly nearer test
      if (det > 0 && u >= 0 && v >= 0 && u + v <= det && t > 0 &&
          (!found || 128'(t) * 128'(best_det) < 128'(best_t) * 128'(det))) begin
        found = 1'b1;
        best_t = t;
        best_det = det;
        n = cross3(e1, e2);
        exp_sid = tri_sid[i];
        exp_v0 = tri_v0[i];
        exp_v1 = tri_v1[i];
        exp_v2 = tri_v2[i];
        exp_norm = {n.z[31:0], n.y[31:0], n.x[31:0]};
      end
    end
  endtask

  //////////////////////////////
  // store loading
  //////////////////////////////
  task automatic set_tri(input int i, input logic [vec_bits-1:0] a,
                         input logic [vec_bits-1:0] b, input logic [vec_bits-1:0] c,
                         input int sid);
    tri_v0[i] = a;
    tri_v1[i] = b;
    tri_v2[i] = c;
    tri_sid[i] = sid;
  endtask

  // right triangle in a z plane facing +z
  task automatic flat_tri(input int i, input int z, input int size, input int sid);
    set_tri(i, vec(0, 0, z), vec(size, 0, z), vec(0, size, z), sid);
  endtask

  task automatic clear_tris();
    for (int i = 0; i < ntri; i++) begin
      set_tri(i, vec(i, i, i), vec(i, i, i), vec(i, i, i), i + 100); // degenerate
    end
  endtask

  task automatic load_tris();
    for (int i = 0; i < ntri; i++) begin
      tri_we = 1'b1;
      tri_waddr = addr_bits'(i);
      tri_v0_w = tri_v0[i];
      tri_v1_w = tri_v1[i];
      tri_v2_w = tri_v2[i];
      tri_sid_w = tri_sid[i];
      @(negedge clk);
    end
    tri_we = 1'b0;
  endtask

  function automatic int rnd(input int span);
    return $random(seed) % span;
  endfunction

  // poke > 0 offers a second ray that many cycles into the busy window
  task automatic run_ray(input logic [vec_bits-1:0] o, input logic [vec_bits-1:0] d,
                         input logic [tid_bits-1:0] tid, input int poke);
    int lat;
    predict(o, d);
    while (!ray_ready) @(negedge clk);
    orig_in = o;
    dir_in = d;
    thread_id_in = tid;
    ray_start = 1'b1;
    @(negedge clk);
    ray_start = 1'b0;
    lat = 0;
    while (!result_valid) begin
      check_value("ray_ready", 128'(ray_ready), 128'(1'b0));
      if (poke > 0 && lat == poke) begin
        orig_in = vec(100, 100, 20);
        dir_in = vec(0, 0, 1);
        thread_id_in = ~tid;
        ray_start = 1'b1;
      end else begin
        ray_start = 1'b0;
      end
      @(negedge clk);
      lat++;
    end
    check_value("latency", 128'(lat), 128'(4 * ntri + 3));
    check_value("ray_ready", 128'(ray_ready), 128'(1'b1));
    check_value("thread_id_out", 128'(thread_id_out), 128'(tid));
    check_value("hit_sid", 128'(hit_sid), 128'(exp_sid));
    check_value("hit_v0", 128'(hit_v0), 128'(exp_v0));
    check_value("hit_v1", 128'(hit_v1), 128'(exp_v1));
    check_value("hit_v2", 128'(hit_v2), 128'(exp_v2));
    check_value("hit_norm", 128'(hit_norm), 128'(exp_norm));
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic single_hit();
    clear_tris();
    flat_tri(3, 10, 10, 'h55);
    load_tris();
    run_ray(vec(2, 2, 20), vec(0, 0, -1), tid_bits'(7), 0);
  endtask

  task automatic miss_cases();
    clear_tris();
    flat_tri(0, 10, 10, 'h21);
    load_tris();
    run_ray(vec(20, 20, 20), vec(0, 0, -1), tid_bits'(1), 0); // outside
    run_ray(vec(2, 2, 0), vec(0, 0, 1), tid_bits'(2), 0);     // back face
  endtask

  task automatic nearest_of_several();
    clear_tris();
    flat_tri(5, 3, 10, 'h31);
    flat_tri(1, 15, 10, 'h32);
    flat_tri(6, 10, 10, 'h33);
    flat_tri(0, 25, 10, 'h34); // behind the origin
    load_tris();
    run_ray(vec(2, 2, 20), vec(0, 0, -1), tid_bits'(4), 0);
    // equal depth with a different det where index 2 should win
    clear_tris();
    flat_tri(4, 15, 10, 'h42);
    flat_tri(2, 15, 20, 'h41);
    flat_tri(6, 10, 10, 'h43);
    load_tris();
    run_ray(vec(2, 2, 20), vec(0, 0, -1), tid_bits'(8), 0);
  endtask

  // last slot, so the core still reads the ray after the poke
  task automatic busy_ray_ignored();
    clear_tris();
    flat_tri(ntri - 1, 10, 10, 'h77);
    load_tris();
    run_ray(vec(2, 2, 20), vec(0, 0, -1), tid_bits'(3), 6);
    run_ray(vec(3, 1, 40), vec(0, 0, -2), tid_bits'(9), 0);
  endtask

  task automatic random_rays();
    for (int r = 0; r < rand_rounds; r++) begin
      for (int i = 0; i < ntri; i++) begin
        set_tri(i, vec(rnd(64), rnd(64), rnd(64)), vec(rnd(64), rnd(64), rnd(64)),
                vec(rnd(64), rnd(64), rnd(64)), $random(seed) | 1);
      end
      load_tris();
      run_ray(vec(rnd(32), rnd(32), 200), vec(rnd(4), rnd(4), -1 - (rnd(8) & 7)),
              tid_bits'($random(seed)), 0);
    end
  endtask

  // back to back rays with the second offered in the result cycle
  task automatic result_timing();
    clear_tris();
    flat_tri(7, 10, 10, 'h66);
    load_tris();
    run_ray(vec(1, 1, 30), vec(0, 0, -1), tid_bits'(5), 0);
    run_ray(vec(4, 4, 30), vec(0, 0, -3), tid_bits'(6), 0);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    ray_start = 1'b0;
    orig_in = '0;
    dir_in = '0;
    thread_id_in = '0;
    tri_we = 1'b0;
    tri_waddr = '0;
    tri_v0_w = '0;
    tri_v1_w = '0;
    tri_v2_w = '0;
    tri_sid_w = '0;
    seed = 32'hd69d;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    single_hit();
    miss_cases();
    nearest_of_several();
    busy_ray_ignored();
    random_rays();
    result_timing();
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* verification/isect_assertions.sv */
`timescale 1ns/1ps

module isect_assertions (
  input logic clk,
  input logic rst,
  input logic ray_start,
  input logic ray_ready,
  input logic ic_start,
  input logic result_valid
);

  //////////////////////////////
  // start pulse
  //////////////////////////////
  // ray latched on the accepting edge, ic_start in the cycle after
  assert property (@(posedge clk) disable iff (rst)
    $past(ray_start && ray_ready, 2) |-> ic_start)
    else $error("ic_start missing after an accepted ray");

  assert property (@(posedge clk) disable iff (rst)
    ic_start |-> $past(ray_start && ray_ready, 2))
    else $error("ic_start without an accepted ray");

  //////////////////////////////
  // result and ready
  //////////////////////////////
  assert property (@(posedge clk) disable iff (rst)
    result_valid |=> !result_valid)
    else $error("result_valid longer than one cycle");

  assert property (@(posedge clk) disable iff (rst)
    ic_start |-> !ray_ready)
    else $error("ray_ready high while the core starts");

  // ready only comes back with the result
  assert property (@(posedge clk) disable iff (rst)
    $rose(ray_ready) |-> result_valid)
    else $error("ray_ready rose before result_valid");

endmodule

bind ic_mem_manager isect_assertions u_assert (
  .clk          (clk),
  .rst          (rst),
  .ray_start    (ray_start),
  .ray_ready    (ray_ready),
  .ic_start     (ic_start),
  .result_valid (result_valid)
);

/* verilog/isect_top.sv */
`timescale 1ns/1ps

module isect_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        ray_start,
  input  logic [rt_pkg::vec_w-1:0]    orig_in,
  input  logic [rt_pkg::vec_w-1:0]    dir_in,
  input  logic [rt_pkg::thread_w-1:0] thread_id_in,
  input  logic                        tri_we,
  input  logic [rt_pkg::tri_aw-1:0]   tri_waddr,
  input  logic [rt_pkg::vec_w-1:0]    tri_v0_w,
  input  logic [rt_pkg::vec_w-1:0]    tri_v1_w,
  input  logic [rt_pkg::vec_w-1:0]    tri_v2_w,
  input  logic [rt_pkg::sid_w-1:0]    tri_sid_w,
  output logic                        ray_ready,
  output logic                        result_valid,
  output logic [rt_pkg::thread_w-1:0] thread_id_out,
  output logic [rt_pkg::vec_w-1:0]    hit_v0,
  output logic [rt_pkg::vec_w-1:0]    hit_v1,
  output logic [rt_pkg::vec_w-1:0]    hit_v2,
  output logic [rt_pkg::vec_w-1:0]    hit_norm,
  output logic [rt_pkg::sid_w-1:0]    hit_sid
);

  logic                        ic_start;
  logic                        ic_done;
  logic [rt_pkg::vec_w-1:0]    ray_orig;
  logic [rt_pkg::vec_w-1:0]    ray_dir;
  logic [rt_pkg::thread_w-1:0] core_thread_id;
  logic [rt_pkg::tri_aw-1:0]   rd_addr;

  // store to core
  logic [rt_pkg::vec_w-1:0]    mem_v0;
  logic [rt_pkg::vec_w-1:0]    mem_v1;
  logic [rt_pkg::vec_w-1:0]    mem_v2;
  logic [rt_pkg::sid_w-1:0]    mem_sid;

  // core to manager
  logic [rt_pkg::vec_w-1:0]    core_v0;
  logic [rt_pkg::vec_w-1:0]    core_v1;
  logic [rt_pkg::vec_w-1:0]    core_v2;
  logic [rt_pkg::vec_w-1:0]    core_norm;
  logic [rt_pkg::sid_w-1:0]    core_sid;

  ic_mem_manager u_mgr (
    .clk              (clk),
    .rst              (rst),
    .ray_start        (ray_start),
    .ic_done          (ic_done),
    .thread_id_mem_in (thread_id_in),
    .thread_id_ic_in  (core_thread_id),
    .orig_in          (orig_in),
    .dir_in           (dir_in),
    .v0_in            (core_v0),
    .v1_in            (core_v1),
    .v2_in            (core_v2),
    .norm_in          (core_norm),
    .sid_in           (core_sid),
    .ray_ready        (ray_ready),
    .ic_start         (ic_start),
    .thread_id_out    (thread_id_out),
    .orig_out         (ray_orig),
    .dir_out          (ray_dir),
    .v0_out           (hit_v0),
    .v1_out           (hit_v1),
    .v2_out           (hit_v2),
    .norm_out         (hit_norm),
    .sid_out          (hit_sid),
    .result_valid     (result_valid)
  );

  isect_core u_core (
    .clk           (clk),
    .rst           (rst),
    .start         (ic_start),
    .orig          (ray_orig),
    .dir           (ray_dir),
    .thread_id_in  (thread_id_out),
    .v0            (mem_v0),
    .v1            (mem_v1),
    .v2            (mem_v2),
    .sid           (mem_sid),
    .rd_addr       (rd_addr),
    .done          (ic_done),
    .hit_v0        (core_v0),
    .hit_v1        (core_v1),
    .hit_v2        (core_v2),
    .hit_sid       (core_sid),
    .hit_norm      (core_norm),
    .thread_id_out (core_thread_id)
  );

  tri_mem u_mem (
    .clk     (clk),
    .we      (tri_we),
    .waddr   (tri_waddr),
    .v0_w    (tri_v0_w),
    .v1_w    (tri_v1_w),
    .v2_w    (tri_v2_w),
    .sid_w   (tri_sid_w),
    .rd_addr (rd_addr),
    .v0      (mem_v0),
    .v1      (mem_v1),
    .v2      (mem_v2),
    .sid     (mem_sid)
  );

endmodule

/* verilog/ic_mem_manager.sv */
`timescale 1ns/1ps

module ic_mem_manager (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        ray_start,
  input  logic                        ic_done,
  input  logic [rt_pkg::thread_w-1:0] thread_id_mem_in,
  input  logic [rt_pkg::thread_w-1:0] thread_id_ic_in,
  input  logic [rt_pkg::vec_w-1:0]    orig_in,
  input  logic [rt_pkg::vec_w-1:0]    dir_in,
  input  logic [rt_pkg::vec_w-1:0]    v0_in,
  input  logic [rt_pkg::vec_w-1:0]    v1_in,
  input  logic [rt_pkg::vec_w-1:0]    v2_in,
  input  logic [rt_pkg::vec_w-1:0]    norm_in,
  input  logic [rt_pkg::sid_w-1:0]    sid_in,
  output logic                        ray_ready,
  output logic                        ic_start,
  output logic [rt_pkg::thread_w-1:0] thread_id_out,
  output logic [rt_pkg::vec_w-1:0]    orig_out,
  output logic [rt_pkg::vec_w-1:0]    dir_out,
  output logic [rt_pkg::vec_w-1:0]    v0_out,
  output logic [rt_pkg::vec_w-1:0]    v1_out,
  output logic [rt_pkg::vec_w-1:0]    v2_out,
  output logic [rt_pkg::vec_w-1:0]    norm_out,
  output logic [rt_pkg::sid_w-1:0]    sid_out,
  output logic                        result_valid
);

  typedef enum logic {st_idle, st_busy} state_t;

  state_t state;
  logic   ld_in;
  logic   ld_out;
  logic   start_pend;

  assign ld_in     = (state == st_idle) && ray_start; // ignored while busy
  assign ld_out    = (state == st_busy) && ic_done;
  assign ray_ready = (state == st_idle);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= st_idle;
      start_pend   <= 1'b0;
      ic_start     <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      start_pend   <= ld_in;
      ic_start     <= start_pend; // one cycle after the ray is latched
      result_valid <= ld_out;
      if (ld_in) begin
        state <= st_busy;
      end else if (ld_out) begin
        state <= st_idle;
      end
    end
  end

  //////////////////////////////
  // ray and result registers
  //////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      thread_id_out <= '0;
      orig_out      <= '0;
      dir_out       <= '0;
      v0_out        <= '0;
      v1_out        <= '0;
      v2_out        <= '0;
      norm_out      <= '0;
      sid_out       <= '0;
    end else if (ld_in) begin
      orig_out      <= orig_in;
      dir_out       <= dir_in;
      thread_id_out <= thread_id_mem_in;
    end else if (ld_out) begin
      v0_out        <= v0_in;
      v1_out        <= v1_in;
      v2_out        <= v2_in;
      norm_out      <= norm_in;
      sid_out       <= sid_in;
      thread_id_out <= thread_id_ic_in; // same register, now the result tag
    end
  end

endmodule

/* verilog/isect_core.sv */
`timescale 1ns/1ps

module isect_core (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  input  logic [rt_pkg::vec_w-1:0]    orig,
  input  logic [rt_pkg::vec_w-1:0]    dir,
  input  logic [rt_pkg::thread_w-1:0] thread_id_in,
  input  logic [rt_pkg::vec_w-1:0]    v0,
  input  logic [rt_pkg::vec_w-1:0]    v1,
  input  logic [rt_pkg::vec_w-1:0]    v2,
  input  logic [rt_pkg::sid_w-1:0]    sid,
  output logic [rt_pkg::tri_aw-1:0]   rd_addr,
  output logic                        done,
  output logic [rt_pkg::vec_w-1:0]    hit_v0,
  output logic [rt_pkg::vec_w-1:0]    hit_v1,
  output logic [rt_pkg::vec_w-1:0]    hit_v2,
  output logic [rt_pkg::sid_w-1:0]    hit_sid,
  output logic [rt_pkg::vec_w-1:0]    hit_norm,
  output logic [rt_pkg::thread_w-1:0] thread_id_out
);

  typedef logic signed [rt_pkg::dot_w-1:0] sval_t;
  typedef logic signed [rt_pkg::cmp_w-1:0] wval_t;
  typedef logic [rt_pkg::lane_w-1:0] lane_t;
  typedef logic [rt_pkg::tri_aw-1:0] addr_t;

  typedef struct packed {
    sval_t x;
    sval_t y;
    sval_t z;
  } vec3_t;

  typedef enum logic [1:0] {ph_addr, ph_read, ph_calc, ph_upd} phase_t;

  //////////////////////////////
  // vector helpers
  //////////////////////////////
  function automatic vec3_t unpack_vec(input logic [rt_pkg::vec_w-1:0] raw);
    vec3_t r;
    r.x = sval_t'(signed'(raw[0*rt_pkg::lane_w +: rt_pkg::coord_w]));
    r.y = sval_t'(signed'(raw[1*rt_pkg::lane_w +: rt_pkg::coord_w]));
    r.z = sval_t'(signed'(raw[2*rt_pkg::lane_w +: rt_pkg::coord_w]));
    return r;
  endfunction

  function automatic logic [rt_pkg::vec_w-1:0] pack_vec(input vec3_t a);
    return {lane_t'(a.z), lane_t'(a.y), lane_t'(a.x)};
  endfunction

  function automatic vec3_t sub(input vec3_t a, input vec3_t b);
    vec3_t r;
    r.x = a.x - b.x;
    r.y = a.y - b.y;
    r.z = a.z - b.z;
    return r;
  endfunction

  function automatic vec3_t cross_prod(input vec3_t a, input vec3_t b);
    vec3_t r;
    r.x = a.y * b.z - a.z * b.y;
    r.y = a.z * b.x - a.x * b.z;
    r.z = a.x * b.y - a.y * b.x;
    return r;
  endfunction

  function automatic sval_t dot(input vec3_t a, input vec3_t b);
    return a.x * b.x + a.y * b.y + a.z * b.z;
  endfunction

  logic   busy;
  phase_t phase;
  addr_t  idx;

  vec3_t orig_v;
  vec3_t dir_v;

  // read stage
  logic [rt_pkg::vec_w-1:0] cur_v0;
  logic [rt_pkg::vec_w-1:0] cur_v1;
  logic [rt_pkg::vec_w-1:0] cur_v2;
  logic [rt_pkg::sid_w-1:0] cur_sid;
  vec3_t e1_r;
  vec3_t e2_r;
  vec3_t s_r;

  // cross/dot stage
  vec3_t p;
  vec3_t q;
  vec3_t n_r;
  sval_t det_r;
  sval_t u_r;
  sval_t v_r;
  sval_t t_r;

  // nearest hit so far
  logic  best_valid;
  sval_t best_det;
  sval_t best_t;

  logic  hit;
  logic  closer;
  wval_t lhs;
  wval_t rhs;

  assign orig_v  = unpack_vec(orig);
  assign dir_v   = unpack_vec(dir);
  assign rd_addr = idx;

  assign p = cross_prod(dir_v, e2_r);
  assign q = cross_prod(s_r, e1_r);

  // culled test without division with all terms scaled by det
  assign hit = (det_r > 0) && (u_r >= 0) && (v_r >= 0) &&
               (u_r + v_r <= det_r) && (t_r > 0);

  // t/det < best_t/best_det with both dets positive
  assign lhs    = wval_t'(t_r) * wval_t'(best_det);
  assign rhs    = wval_t'(best_t) * wval_t'(det_r);
  assign closer = !best_valid || (lhs < rhs); // strict so the lower index keeps a tie

  always_ff @(posedge clk) begin
    if (phase == ph_read) begin
      cur_v0  <= v0;
      cur_v1  <= v1;
      cur_v2  <= v2;
      cur_sid <= sid;
      e1_r    <= sub(unpack_vec(v1), unpack_vec(v0));
      e2_r    <= sub(unpack_vec(v2), unpack_vec(v0));
      s_r     <= sub(orig_v, unpack_vec(v0));
    end
    if (phase == ph_calc) begin
      det_r <= dot(e1_r, p);
      u_r   <= dot(s_r, p);
      v_r   <= dot(dir_v, q);
      t_r   <= dot(e2_r, q);
      n_r   <= cross_prod(e1_r, e2_r); // unnormalised face normal
    end
  end

  always_ff @(posedge clk) begin
    if (busy && phase == ph_upd && hit && closer) begin
      best_det <= det_r;
      best_t   <= t_r;
    end
  end

  //////////////////////////////
  // triangle loop
  //////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy          <= 1'b0;
      phase         <= ph_addr;
      idx           <= '0;
      done          <= 1'b0;
      best_valid    <= 1'b0;
      hit_v0        <= '0;
      hit_v1        <= '0;
      hit_v2        <= '0;
      hit_sid       <= '0;
      hit_norm      <= '0;
      thread_id_out <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy          <= 1'b1;
        phase         <= ph_addr;
        idx           <= '0;
        best_valid    <= 1'b0; // miss result unless a hit replaces it
        hit_v0        <= '0;
        hit_v1        <= '0;
        hit_v2        <= '0;
        hit_sid       <= '0;
        hit_norm      <= '0;
        thread_id_out <= thread_id_in;
      end else if (busy) begin
        phase <= phase_t'(phase + 2'd1);
        if (phase == ph_upd) begin
          if (hit && closer) begin
            best_valid <= 1'b1;
            hit_v0     <= cur_v0;
            hit_v1     <= cur_v1;
            hit_v2     <= cur_v2;
            hit_sid    <= cur_sid;
            hit_norm   <= pack_vec(n_r);
          end
          idx <= idx + 1'b1;
          if (idx == addr_t'(rt_pkg::num_tri - 1)) begin
            busy <= 1'b0;
            done <= 1'b1;
          end
        end
      end
    end
  end

endmodule

/* verilog/tri_mem.sv */
`timescale 1ns/1ps

module tri_mem (
  input  logic                      clk,
  input  logic                      we,
  input  logic [rt_pkg::tri_aw-1:0] waddr,
  input  logic [rt_pkg::vec_w-1:0]  v0_w,
  input  logic [rt_pkg::vec_w-1:0]  v1_w,
  input  logic [rt_pkg::vec_w-1:0]  v2_w,
  input  logic [rt_pkg::sid_w-1:0]  sid_w,
  input  logic [rt_pkg::tri_aw-1:0] rd_addr,
  output logic [rt_pkg::vec_w-1:0]  v0,
  output logic [rt_pkg::vec_w-1:0]  v1,
  output logic [rt_pkg::vec_w-1:0]  v2,
  output logic [rt_pkg::sid_w-1:0]  sid
);

  logic [rt_pkg::vec_w-1:0] mem_v0 [rt_pkg::num_tri];
  logic [rt_pkg::vec_w-1:0] mem_v1 [rt_pkg::num_tri];
  logic [rt_pkg::vec_w-1:0] mem_v2 [rt_pkg::num_tri];
  logic [rt_pkg::sid_w-1:0] mem_sid [rt_pkg::num_tri];

  // loader port
  always_ff @(posedge clk) begin
    if (we) begin
      mem_v0[waddr]  <= v0_w;
      mem_v1[waddr]  <= v1_w;
      mem_v2[waddr]  <= v2_w;
      mem_sid[waddr] <= sid_w;
    end
  end

  // registered read, data one cycle after rd_addr
  always_ff @(posedge clk) begin
    v0  <= mem_v0[rd_addr];
    v1  <= mem_v1[rd_addr];
    v2  <= mem_v2[rd_addr];
    sid <= mem_sid[rd_addr];
  end

endmodule

/* verilog/rt_pkg.sv */
package rt_pkg;

  //////////////////////////////
  // ray threads
  //////////////////////////////
  localparam int num_thread = 32;
  localparam int thread_w   = $clog2(num_thread); // 5

  //////////////////////////////
  // triangle store
  //////////////////////////////
  localparam int num_tri = 8;
  localparam int tri_aw  = $clog2(num_tri);

  //////////////////////////////
  // vectors and arithmetic
  //////////////////////////////
  // three 32-bit lanes, x in the low lane
  localparam int vec_w   = 96;
  localparam int lane_w  = 32;
  localparam int coord_w = 10; // signed, rest of lane is sign extension

  // sid 0 is reserved for a miss
  localparam int sid_w = 32;

  localparam int dot_w = 40; // edges, crosses and dot products
  localparam int cmp_w = 80; // t * det cross products for the nearest hit

endpackage
